// ==== common/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
`define CACHE_SETS      16
`define CACHE_WAYS      4
`define CACHE_ADDR_W    32
`define CACHE_LINE_W    64      // bits per line

// widths derived from the geometry
`define CACHE_OFFSET_W  ($clog2(`CACHE_LINE_W / 8))    // byte offset inside a line
`define CACHE_INDEX_W   ($clog2(`CACHE_SETS))
`define CACHE_TAG_W     (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)
`define CACHE_WAY_W     ($clog2(`CACHE_WAYS))

// replacement lfsr
`define CACHE_LFSR_W    8
`define CACHE_LFSR_SEED 8'ha5   // any nonzero value
`define CACHE_LFSR_TAPS 8'hb8   // x^8 + x^6 + x^5 + x^4 + 1

`endif

// ==== common/cache_pkg.sv ====
`include "cache_settings.svh"

package cache_pkg;

    // address split for set lookup
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } cache_addr_fields_t;

    // same address word, raw or decoded
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] word;     // muxing and storage
        cache_addr_fields_t       part;     // tag / index / offset decode
    } cache_addr_u;

    // one stored line with its tag
    typedef struct packed {
        logic                     valid;
        logic [`CACHE_TAG_W-1:0]  tag;
        logic [`CACHE_LINE_W-1:0] data;
    } cache_entry_t;

endpackage

// ==== cache/sram_set.sv ====
`include "cache_settings.svh"

module sram_set
    import cache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CACHE_INDEX_W-1:0] i_index,
    input  logic                      i_read_en,
    input  logic [`CACHE_WAYS-1:0]    i_write_en_vec,
    input  cache_entry_t              i_write_entry,
    output cache_entry_t              o_read_entry [`CACHE_WAYS]
);

    // valid bits live in flops so reset clears every set at once
    logic [`CACHE_SETS-1:0]   valid_q [`CACHE_WAYS];
    logic [`CACHE_TAG_W-1:0]  tag_mem [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_LINE_W-1:0] data_mem [`CACHE_WAYS][`CACHE_SETS];

    logic [`CACHE_WAYS-1:0]   rd_valid_q;
    logic [`CACHE_TAG_W-1:0]  rd_tag_q [`CACHE_WAYS];
    logic [`CACHE_LINE_W-1:0] rd_data_q [`CACHE_WAYS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            rd_valid_q <= '0;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (i_write_en_vec[w]) begin
                    valid_q[w][i_index] <= i_write_entry.valid;
                end
                if (i_read_en) begin
                    rd_valid_q[w] <= valid_q[w][i_index];   // old contents on same-cycle write
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (i_write_en_vec[w]) begin
                tag_mem[w][i_index]  <= i_write_entry.tag;
                data_mem[w][i_index] <= i_write_entry.data;
            end
            if (i_read_en) begin
                rd_tag_q[w]  <= tag_mem[w][i_index];
                rd_data_q[w] <= data_mem[w][i_index];
            end
        end
    end

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_rd
        assign o_read_entry[w] = '{valid: rd_valid_q[w], tag: rd_tag_q[w], data: rd_data_q[w]};
    end

endmodule

// ==== cache/random_rep.sv ====
`include "cache_settings.svh"

module random_rep (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CACHE_WAYS-1:0] i_valid_vec,
    output logic [`CACHE_WAYS-1:0] o_replace_vec
);

    logic [`CACHE_LFSR_W-1:0] lfsr_q;
    logic [`CACHE_LFSR_W-1:0] lfsr_next;
    logic [`CACHE_WAY_W-1:0]  rand_way;
    logic [`CACHE_WAYS-1:0]   invalid_vec;
    logic [`CACHE_WAYS-1:0]   first_invalid;
    logic [`CACHE_WAYS-1:0]   rand_vec;

    // galois form, shift right and fold the taps in on a one
    always_comb begin
        lfsr_next = lfsr_q >> 1;
        if (lfsr_q[0]) begin
            lfsr_next = lfsr_next ^ `CACHE_LFSR_TAPS;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= `CACHE_LFSR_SEED;
        end else begin
            lfsr_q <= lfsr_next;    // free running
        end
    end

    assign invalid_vec   = ~i_valid_vec;
    assign first_invalid = invalid_vec & (~invalid_vec + 1'b1);    // lowest set bit only
    assign rand_way      = lfsr_q[`CACHE_WAY_W-1:0];
    assign rand_vec      = `CACHE_WAYS'(1) << rand_way;

    // empty ways are used up before anything is evicted
    assign o_replace_vec = (|invalid_vec) ? first_invalid : rand_vec;

    a_replace_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot(o_replace_vec)
    );

endmodule

// ==== cache/cache_sram.sv ====
`include "cache_settings.svh"

// s0 sends the read, s1 compares tags and picks a way, s2 holds the line
module cache_sram
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    // lookup
    input  logic                     i_lookup_req,
    output logic                     o_lookup_gnt,
    input  cache_addr_u              i_lookup_addr,
    output logic                     o_lookup_hit,
    output logic                     o_lookup_hit_rdy,
    output logic [`CACHE_WAYS-1:0]   o_lookup_sel_vec,  // victim way on a miss
    output logic [`CACHE_LINE_W-1:0] o_lookup_data,

    // fill write
    input  logic                     i_write_req,
    input  cache_addr_u              i_write_addr,
    input  logic [`CACHE_WAYS-1:0]   i_write_way_vec,
    input  logic [`CACHE_LINE_W-1:0] i_write_data
);

    cache_addr_u              access_addr;
    logic                     read_en;
    logic [`CACHE_WAYS-1:0]   write_en_vec;
    cache_entry_t             write_entry;
    cache_entry_t             read_entry [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]   valid_vec;
    logic [`CACHE_WAYS-1:0]   replace_vec;
    logic [`CACHE_WAYS-1:0]   s1_hit_vec;
    logic                     s1_req;
    cache_addr_u              s1_addr;
    logic [`CACHE_LINE_W-1:0] s2_data_q;

    // s0, the write takes the port and the lookup waits
    assign read_en      = i_lookup_req && !i_write_req;
    assign o_lookup_gnt = read_en;
    assign access_addr  = i_write_req ? i_write_addr : i_lookup_addr;
    assign write_en_vec = i_write_req ? i_write_way_vec : '0;
    assign write_entry  = '{valid: 1'b1, tag: i_write_addr.part.tag, data: i_write_data};

    sram_set u_sram_set (
        .clk            (clk),
        .rst            (rst),
        .i_index        (access_addr.part.index),
        .i_read_en      (read_en),
        .i_write_en_vec (write_en_vec),
        .i_write_entry  (write_entry),
        .o_read_entry   (read_entry)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_req <= 1'b0;
        end else begin
            s1_req <= read_en;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= access_addr;   // tag needed for the s1 compare
    end

    // s1 tag compare
    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_cmp
        assign valid_vec[w]  = read_entry[w].valid;
        assign s1_hit_vec[w] = s1_req && read_entry[w].valid
                               && (read_entry[w].tag == s1_addr.part.tag);
    end

    random_rep u_random_rep (
        .clk           (clk),
        .rst           (rst),
        .i_valid_vec   (valid_vec),
        .o_replace_vec (replace_vec)
    );

    assign o_lookup_hit     = |s1_hit_vec;
    assign o_lookup_hit_rdy = s1_req;
    assign o_lookup_sel_vec = o_lookup_hit ? s1_hit_vec : replace_vec;

    // s2, hit line or the line about to be replaced
    always_ff @(posedge clk) begin
        if (s1_req) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (o_lookup_sel_vec[w]) begin
                    s2_data_q <= read_entry[w].data;
                end
            end
        end
    end

    assign o_lookup_data = s2_data_q;

    a_write_way_onehot: assert property (
        @(posedge clk) disable iff (rst) i_write_req |-> $onehot0(i_write_way_vec)
    );

    // a line is never filled into two ways of one set
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(s1_hit_vec)
    );

endmodule

// ==== source/cache_ctrl.sv ====
`include "cache_settings.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    // client, four-phase
    input  logic                     i_req,
    input  logic [`CACHE_ADDR_W-1:0] i_addr,
    output logic                     o_ack,
    output logic [`CACHE_LINE_W-1:0] o_data,

    // backing memory, four-phase
    output logic                     o_mem_req,
    output logic [`CACHE_ADDR_W-1:0] o_mem_addr,
    input  logic                     i_mem_ack,
    input  logic [`CACHE_LINE_W-1:0] i_mem_data,

    // cache_sram side
    output logic                     o_lookup_req,
    input  logic                     i_lookup_gnt,
    output cache_addr_u              o_lookup_addr,
    input  logic                     i_lookup_hit,
    input  logic                     i_lookup_hit_rdy,
    input  logic [`CACHE_WAYS-1:0]   i_lookup_sel_vec,
    input  logic [`CACHE_LINE_W-1:0] i_lookup_data,
    output logic                     o_write_req,
    output cache_addr_u              o_write_addr,
    output logic [`CACHE_WAYS-1:0]   o_write_way_vec,
    output logic [`CACHE_LINE_W-1:0] o_write_data
);

    localparam logic [3:0] ST_IDLE      = 4'd0;
    localparam logic [3:0] ST_LOOKUP    = 4'd1;
    localparam logic [3:0] ST_HIT_WAIT  = 4'd2;    // sel_vec latched here
    localparam logic [3:0] ST_DATA_WAIT = 4'd3;
    localparam logic [3:0] ST_MEM_REQ   = 4'd4;
    localparam logic [3:0] ST_MEM_REL   = 4'd5;
    localparam logic [3:0] ST_FILL      = 4'd6;
    localparam logic [3:0] ST_RELOOKUP  = 4'd7;
    localparam logic [3:0] ST_ACK       = 4'd8;
    localparam logic [3:0] ST_RELEASE   = 4'd9;

    logic [3:0]               state_q;
    cache_addr_u              req_addr_q;
    cache_addr_u              line_addr;
    logic [`CACHE_WAYS-1:0]   victim_q;
    logic [`CACHE_LINE_W-1:0] fill_data_q;
    logic [`CACHE_LINE_W-1:0] data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:      if (i_req) state_q <= ST_LOOKUP;
                ST_LOOKUP:    if (i_lookup_gnt) state_q <= ST_HIT_WAIT;
                ST_HIT_WAIT: begin
                    if (i_lookup_hit_rdy) begin
                        state_q <= i_lookup_hit ? ST_DATA_WAIT : ST_MEM_REQ;
                    end
                end
                ST_DATA_WAIT: state_q <= ST_ACK;
                ST_MEM_REQ:   if (i_mem_ack) state_q <= ST_MEM_REL;
                ST_MEM_REL:   if (!i_mem_ack) state_q <= ST_FILL;
                ST_FILL:      state_q <= ST_RELOOKUP;
                ST_RELOOKUP:  if (i_lookup_gnt) state_q <= ST_HIT_WAIT;   // now a hit
                ST_ACK:       if (!i_req) state_q <= ST_RELEASE;
                ST_RELEASE:   state_q <= ST_IDLE;    // ack seen low before next req
                default:      state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && i_req) begin
            req_addr_q <= i_addr;
        end
        if (state_q == ST_HIT_WAIT && i_lookup_hit_rdy && !i_lookup_hit) begin
            victim_q <= i_lookup_sel_vec;
        end
        if (state_q == ST_MEM_REQ && i_mem_ack) begin
            fill_data_q <= i_mem_data;
        end
        if (state_q == ST_DATA_WAIT) begin
            data_q <= i_lookup_data;
        end
    end

    // memory works on whole lines
    always_comb begin
        line_addr = req_addr_q;
        line_addr.part.offset = '0;
    end

    assign o_ack        = (state_q == ST_ACK);
    assign o_data       = data_q;
    assign o_mem_req    = (state_q == ST_MEM_REQ);
    assign o_mem_addr   = line_addr.word;

    assign o_lookup_req    = (state_q == ST_LOOKUP) || (state_q == ST_RELOOKUP);
    assign o_lookup_addr   = req_addr_q;
    assign o_write_req     = (state_q == ST_FILL);     // single cycle
    assign o_write_addr    = req_addr_q;
    assign o_write_way_vec = victim_q;
    assign o_write_data    = fill_data_q;

    // a fetch only follows a lookup that missed
    a_fetch_after_miss: assert property (
        @(posedge clk) disable iff (rst)
        $rose(o_mem_req) |-> $past(i_lookup_hit_rdy && !i_lookup_hit)
    );

endmodule

// ==== source/cache_top.sv ====
`include "cache_settings.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_req,
    input  logic [`CACHE_ADDR_W-1:0] i_addr,
    output logic                     o_ack,
    output logic [`CACHE_LINE_W-1:0] o_data,
    output logic                     o_mem_req,
    output logic [`CACHE_ADDR_W-1:0] o_mem_addr,
    input  logic                     i_mem_ack,
    input  logic [`CACHE_LINE_W-1:0] i_mem_data
);

    logic                     lookup_req;
    logic                     lookup_gnt;
    cache_addr_u              lookup_addr;
    logic                     lookup_hit;
    logic                     lookup_hit_rdy;
    logic [`CACHE_WAYS-1:0]   lookup_sel_vec;
    logic [`CACHE_LINE_W-1:0] lookup_data;
    logic                     write_req;
    cache_addr_u              write_addr;
    logic [`CACHE_WAYS-1:0]   write_way_vec;
    logic [`CACHE_LINE_W-1:0] write_data;

    cache_ctrl u_cache_ctrl (
        .clk              (clk),
        .rst              (rst),
        .i_req            (i_req),
        .i_addr           (i_addr),
        .o_ack            (o_ack),
        .o_data           (o_data),
        .o_mem_req        (o_mem_req),
        .o_mem_addr       (o_mem_addr),
        .i_mem_ack        (i_mem_ack),
        .i_mem_data       (i_mem_data),
        .o_lookup_req     (lookup_req),
        .i_lookup_gnt     (lookup_gnt),
        .o_lookup_addr    (lookup_addr),
        .i_lookup_hit     (lookup_hit),
        .i_lookup_hit_rdy (lookup_hit_rdy),
        .i_lookup_sel_vec (lookup_sel_vec),
        .i_lookup_data    (lookup_data),
        .o_write_req      (write_req),
        .o_write_addr     (write_addr),
        .o_write_way_vec  (write_way_vec),
        .o_write_data     (write_data)
    );

    cache_sram u_cache_sram (
        .clk              (clk),
        .rst              (rst),
        .i_lookup_req     (lookup_req),
        .o_lookup_gnt     (lookup_gnt),
        .i_lookup_addr    (lookup_addr),
        .o_lookup_hit     (lookup_hit),
        .o_lookup_hit_rdy (lookup_hit_rdy),
        .o_lookup_sel_vec (lookup_sel_vec),
        .o_lookup_data    (lookup_data),
        .i_write_req      (write_req),
        .i_write_addr     (write_addr),
        .i_write_way_vec  (write_way_vec),
        .i_write_data     (write_data)
    );

endmodule

// ==== testbench/tb_clkgen.sv ====
module tb_clkgen (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;    // 8 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (8) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// ==== testbench/tb_checker.sv ====
`include "cache_settings.svh"

module tb_checker (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_req,
    input  logic [`CACHE_ADDR_W-1:0] i_addr,
    input  logic                     i_ack,
    input  logic [`CACHE_LINE_W-1:0] i_data,
    input  logic                     i_mem_req,
    input  logic [`CACHE_ADDR_W-1:0] i_mem_addr,
    output int                       o_tests,
    output int                       o_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] KIND_MISS  = 2'd0;
    localparam logic [1:0] KIND_ANY   = 2'd2;    // line of a full set, maybe evicted
    localparam int         HIT_CYCLES = 3;

    string      cur_name = "none";
    logic [1:0] cur_kind = KIND_MISS;
    bit         any_missed;
    bit         active;
    bit         acked;
    bit         ack_d;
    bit         mem_req_d;
    int         cycle;
    int         req_cyc;
    int         lat;
    int         fetches;
    int         test_errs;

    function automatic logic [`CACHE_ADDR_W-1:0] line_of(input logic [`CACHE_ADDR_W-1:0] a);
        return {a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    endfunction

    task automatic report_mismatch(input string what, input logic [`CACHE_LINE_W-1:0] exp,
                                   input logic [`CACHE_LINE_W-1:0] act);
        $display("mismatch %s %s: expected %0h actual %0h", cur_name, what, exp, act);
        test_errs++;
        o_errors++;
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", cur_name, msg);
        test_errs++;
        o_errors++;
    endtask

    // called by the testbench top before each request
    task automatic begin_test(input string name, input logic [1:0] kind);
        if (cur_kind == KIND_ANY && kind != KIND_ANY && !any_missed) begin
            report_error("five lines of one 4-way set were all still present");
        end
        if (kind == KIND_ANY && cur_kind != KIND_ANY) begin
            any_missed = 1'b0;
        end
        cur_name  = name;
        cur_kind  = kind;
        test_errs = 0;
    endtask

    task automatic finish_test();
        int exp_fetch;
        exp_fetch = (cur_kind == KIND_MISS) ? 1 : 0;
        if (cur_kind == KIND_ANY && fetches == 1) begin
            any_missed = 1'b1;
            exp_fetch  = 1;
        end
        if (fetches != exp_fetch) begin
            report_mismatch("fetch count", exp_fetch, fetches);
        end
        if (fetches == 0 && lat != HIT_CYCLES) begin
            report_mismatch("hit latency", HIT_CYCLES, lat);
        end
        o_tests++;
        $display("test %0d %s: %s, %0d fetch(es), ack after %0d cycles", o_tests, cur_name,
                 (test_errs == 0) ? "pass" : "fail", fetches, lat);
        active = 1'b0;
        acked  = 1'b0;
    endtask

    always @(posedge i_clk) begin
        if (i_rst) begin
            active    = 1'b0;
            acked     = 1'b0;
            ack_d     = 1'b0;
            mem_req_d = 1'b0;
            cycle     = 0;
            o_tests   = 0;
            o_errors  = 0;
        end else begin
            cycle++;
            if (!active && i_req && !i_ack) begin
                active  = 1'b1;
                fetches = 0;
                req_cyc = cycle;
            end
            if (i_mem_req && !mem_req_d) begin
                fetches++;
                if (i_mem_addr !== line_of(i_addr)) begin
                    report_mismatch("fetch address", line_of(i_addr), i_mem_addr);
                end
                if (!active || acked) begin
                    report_error("memory fetch outside a pending request");
                end
            end
            if (active && i_ack && !ack_d) begin
                acked = 1'b1;
                lat   = cycle - req_cyc - 1;    // ack is registered one edge before we see it
                if (i_data !== {line_of(i_addr), ~line_of(i_addr)}) begin
                    report_mismatch("data", {line_of(i_addr), ~line_of(i_addr)}, i_data);
                end
            end
            if (acked && i_req && !i_ack) begin
                report_error("o_ack dropped while i_req was still held");
            end
            if (acked && ack_d && !i_ack && !i_req) begin
                finish_test();
            end
            mem_req_d = i_mem_req;
            ack_d     = i_ack;
        end
    end

endmodule

// ==== testbench/tb_cache.sv ====
`include "cache_settings.svh"

module tb_cache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] KIND_MISS      = 2'd0;
    localparam logic [1:0] KIND_HIT       = 2'd1;
    localparam logic [1:0] KIND_ANY       = 2'd2;
    localparam int         CYCLES_PER_ROW = 40;

    logic                     clk;
    logic                     rst;
    logic                     req = 1'b0;
    logic [`CACHE_ADDR_W-1:0] addr = '0;
    logic                     ack;
    logic [`CACHE_LINE_W-1:0] data;
    logic                     mem_req;
    logic [`CACHE_ADDR_W-1:0] mem_addr;
    logic                     mem_ack = 1'b0;
    logic [`CACHE_LINE_W-1:0] mem_data = '0;
    int                       tests;
    int                       errors;

    // memory model
    logic [31:0] lfsr = 32'heff53fdf;
    int          mem_wait;
    int          mem_delay;
    bit          mem_busy;

    // stimulus table
    string                    row_name [$];
    logic [`CACHE_ADDR_W-1:0] row_addr [$];
    logic [1:0]               row_kind [$];
    int                       row_hold [$];    // extra cycles i_req stays high after o_ack

    tb_clkgen u_clkgen (
        .o_clk (clk),
        .o_rst (rst)
    );

    cache_top UUT (
        .clk        (clk),
        .rst        (rst),
        .i_req      (req),
        .i_addr     (addr),
        .o_ack      (ack),
        .o_data     (data),
        .o_mem_req  (mem_req),
        .o_mem_addr (mem_addr),
        .i_mem_ack  (mem_ack),
        .i_mem_data (mem_data)
    );

    tb_checker u_checker (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_req      (req),
        .i_addr     (addr),
        .i_ack      (ack),
        .i_data     (data),
        .i_mem_req  (mem_req),
        .i_mem_addr (mem_addr),
        .o_tests    (tests),
        .o_errors   (errors)
    );

    // x^32 + x^22 + x^2 + x + 1, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_delay(output int d);
        d = 0;
        for (int b = 0; b < 3; b++) begin
            d    = (d << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        d = d + 1;    // 1 to 8 cycles
    endtask

    // backing memory, line data is the line address and its inverse
    always @(posedge clk) begin
        if (rst) begin
            mem_ack  <= 1'b0;
            mem_busy <= 1'b0;
        end else if (mem_ack) begin
            if (!mem_req) mem_ack <= 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 1) begin
                mem_ack  <= 1'b1;
                mem_data <= {mem_addr, ~mem_addr};
                mem_busy <= 1'b0;
            end
            mem_wait <= mem_wait - 1;
        end else if (mem_req) begin
            draw_delay(mem_delay);
            mem_wait <= mem_delay;
            mem_busy <= 1'b1;
        end
    end

    task automatic add_row(input string name, input logic [`CACHE_ADDR_W-1:0] a,
                           input logic [1:0] kind, input int hold);
        row_name.push_back(name);
        row_addr.push_back(a);
        row_kind.push_back(kind);
        row_hold.push_back(hold);
    endtask

    task automatic build_table();
        add_row("cold_line",    32'h0000_1010, KIND_MISS, 0);    // set 2
        add_row("repeat_line",  32'h0000_1010, KIND_HIT,  0);
        add_row("other_offset", 32'h0000_1015, KIND_HIT,  0);
        add_row("set5_tag1",    32'h0000_00a8, KIND_MISS, 0);    // four tags of set 5
        add_row("set5_tag2",    32'h0000_0128, KIND_MISS, 0);
        add_row("set5_tag3",    32'h0000_01ac, KIND_MISS, 0);
        add_row("set5_tag4",    32'h0000_0228, KIND_MISS, 0);
        add_row("hit_tag1",     32'h0000_00a8, KIND_HIT,  0);
        add_row("hit_tag2",     32'h0000_0128, KIND_HIT,  0);
        add_row("hit_tag3",     32'h0000_01a8, KIND_HIT,  0);
        add_row("hit_tag4",     32'h0000_022f, KIND_HIT,  0);
        add_row("set5_tag5",    32'h0000_02a8, KIND_MISS, 0);    // forces an eviction
        add_row("hit_tag5",     32'h0000_02a8, KIND_HIT,  0);
        add_row("probe_tag1",   32'h0000_00a8, KIND_ANY,  0);
        add_row("probe_tag2",   32'h0000_0128, KIND_ANY,  0);
        add_row("probe_tag3",   32'h0000_01a8, KIND_ANY,  0);
        add_row("probe_tag4",   32'h0000_0228, KIND_ANY,  0);
        add_row("held_hit",     32'h0000_1010, KIND_HIT,  6);
        add_row("held_miss",    32'h0000_3000, KIND_MISS, 5);
    endtask

    // one four-phase client transfer
    task automatic run_row(input int i);
        @(posedge clk);
        u_checker.begin_test(row_name[i], row_kind[i]);
        req  <= 1'b1;
        addr <= row_addr[i];
        @(posedge clk);
        while (!ack) @(posedge clk);
        repeat (row_hold[i]) @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
    endtask

    task automatic watchdog();
        repeat (row_addr.size() * CYCLES_PER_ROW) @(posedge clk);
        $display("timeout: the cache did not finish all requests in %0d cycles",
                 row_addr.size() * CYCLES_PER_ROW);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    initial begin
        build_table();
        fork
            watchdog();
        join_none
        wait (rst === 1'b0);
        for (int i = 0; i < row_addr.size(); i++) begin
            run_row(i);
        end
        repeat (2) @(posedge clk);
        $display("tests %0d of %0d, errors %0d", tests, row_addr.size(), errors);
        if (errors == 0 && tests == row_addr.size()) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+common
common/cache_pkg.sv
cache/sram_set.sv
cache/random_rep.sv
cache/cache_sram.sv
source/cache_ctrl.sv
source/cache_top.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_cache.sv

// ==== Bender.yml ====
package:
  name: cache_sram

sources:
  - include_dirs:
      - common
    files:
      - common/cache_pkg.sv
      - cache/sram_set.sv
      - cache/random_rep.sv
      - cache/cache_sram.sv
      - source/cache_ctrl.sv
      - source/cache_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - testbench/tb_clkgen.sv
      - testbench/tb_checker.sv
      - testbench/tb_cache.sv
